//--- common/kin_cfg.svh
/*
  joint count, fixed-point format and schedule slots for the jacobian slice.
  slot counts assume the one-cycle multiplier latency of mult_bank.
*/
`ifndef KIN_CFG_SVH
`define KIN_CFG_SVH

// six-joint arm
`define KIN_JOINTS 6

// signed scalars, 16 fraction bits
`define KIN_FRAC 16
`define KIN_W 27

// step counts of one run
`define KIN_SLOT_CLEAR 0
`define KIN_SLOT_COL_FIRST 1
`define KIN_SLOT_JJT 8
`define KIN_SLOT_JJT_CAPTURE 9
`define KIN_SLOT_LAST 10

// raw lsb value added on the J*J^T diagonal
`define KIN_DAMP_RAW 4

`endif

//--- common/fixed_pkg.sv
/*
  fixed-point scalar, vector and matrix types.
  all arithmetic on these wraps in KIN_W bits.
*/
`include "kin_cfg.svh"

package fixed_pkg;

	// one scalar, two's complement
	typedef logic signed [`KIN_W-1:0] fix_t;

	// step count of the schedule
	typedef logic [7:0] count_t;

	// index 0 is x, 1 is y, 2 is z
	typedef fix_t [2:0] vec3_t;

	// first index row, second index column
	typedef fix_t [`KIN_JOINTS-1:0][`KIN_JOINTS-1:0] mat6_t;

	// pose of the arm as delivered by forward kinematics
	typedef struct packed {
		vec3_t [`KIN_JOINTS-1:0] z;
		vec3_t [`KIN_JOINTS-1:0] p;
		vec3_t                   p_end;
		// 1 marks a prismatic joint
		logic [`KIN_JOINTS-1:0]  joint_type;
	} pose_t;

endpackage

//--- common/mult_bus_pkg.sv
/*
  operand and result buses of the shared multipliers.
  an idle source drives its request bus to zero.
*/
`include "kin_cfg.svh"

package mult_bus_pkg;

	import fixed_pkg::*;

	// six independent lanes
	typedef struct packed {
		fix_t [`KIN_JOINTS-1:0] dataa;
		fix_t [`KIN_JOINTS-1:0] datab;
	} array_req_t;

	// truncated product per lane
	typedef struct packed {
		fix_t [`KIN_JOINTS-1:0] result;
	} array_res_t;

	// result is dataa * datab
	typedef struct packed {
		mat6_t dataa;
		mat6_t datab;
	} mat_req_t;

	// each entry sums six truncated products
	typedef struct packed {
		mat6_t result;
	} mat_res_t;

endpackage

//--- logic/step_sequencer.sv
/*
  accepts start only while idle; the pose is sampled with the start.
  count runs 0 to KIN_SLOT_LAST, done pulses during the last slot.
*/
`timescale 1ns/1ps
`include "kin_cfg.svh"

module step_sequencer
	import fixed_pkg::*;
(
	input  logic   i,
	input  logic   rst,
	input  logic   start,
	input  pose_t  pose_in,
	output pose_t  pose,
	output count_t count,
	output logic   en,
	output logic   busy,
	output logic   done
);

	logic accept;

	assign accept = start && !busy;
	assign en = busy;

	always_ff @(posedge i) begin
		if (rst) begin
			busy  <= 1'b0;
			done  <= 1'b0;
			count <= '0;
		end else if (!busy) begin
			done <= 1'b0;
			if (accept) begin
				busy  <= 1'b1;
				count <= '0;
			end
		end else if (count == count_t'(`KIN_SLOT_LAST)) begin
			// run over, count parks on the last slot
			busy <= 1'b0;
			done <= 1'b0;
		end else begin
			count <= count + count_t'(1);
			done  <= (count == count_t'(`KIN_SLOT_LAST - 1));
		end
	end

	// held for the whole run
	always_ff @(posedge i) begin
		if (accept) begin
			pose <= pose_in;
		end
	end

	a_done_busy: assert property (@(posedge i) disable iff (rst) done |-> busy);

	a_count_range: assert property (@(posedge i) disable iff (rst)
		busy |-> count <= count_t'(`KIN_SLOT_LAST));

endmodule

//--- logic/mult_bank.sv
/*
  products are shifted right by KIN_FRAC and cut to KIN_W bits.
  sums wrap; both results appear one clock after the operands.
*/
`timescale 1ns/1ps
`include "kin_cfg.svh"

module mult_bank
	import fixed_pkg::*;
	import mult_bus_pkg::*;
(
	input  logic       i,
	input  array_req_t array_req,
	output array_res_t array_res,
	input  mat_req_t   mat_req,
	output mat_res_t   mat_res
);

	array_res_t array_next;
	mat_res_t   mat_next;

	// full product, then arithmetic shift and truncation
	function automatic fix_t mul_trunc(input fix_t a, input fix_t b);
		logic signed [2*`KIN_W-1:0] full;
		logic signed [2*`KIN_W-1:0] shifted;
		full = $signed(a) * $signed(b);
		shifted = full >>> `KIN_FRAC;
		return shifted[`KIN_W-1:0];
	endfunction

	// six lanes for the cross products
	always_comb begin
		for (int l = 0; l < `KIN_JOINTS; l++) begin
			array_next.result[l] = mul_trunc(array_req.dataa[l], array_req.datab[l]);
		end
	end

	// row of dataa against column of datab
	always_comb begin
		fix_t acc;
		mat_next = '0;
		for (int r = 0; r < `KIN_JOINTS; r++) begin
			for (int c = 0; c < `KIN_JOINTS; c++) begin
				acc = '0;
				for (int k = 0; k < `KIN_JOINTS; k++) begin
					acc = acc + mul_trunc(mat_req.dataa[r][k], mat_req.datab[k][c]);
				end
				mat_next.result[r][c] = acc;
			end
		end
	end

	// zero operands flush the registers during reset
	always_ff @(posedge i) begin
		array_res <= array_next;
		mat_res   <= mat_next;
	end

endmodule

//--- full_jacobian/jacobian_build.sv
/*
  joint k operands go out in slot KIN_SLOT_COL_FIRST+k, column k is written
  one clock later from the returned products. cleared at KIN_SLOT_CLEAR.
*/
`timescale 1ns/1ps
`include "kin_cfg.svh"

module jacobian_build
	import fixed_pkg::*;
	import mult_bus_pkg::*;
(
	input  logic       i,
	input  logic       rst,
	input  logic       en,
	input  count_t     count,
	input  pose_t      pose,
	output array_req_t array_req,
	input  array_res_t array_res,
	output mat6_t      jacobian_matrix
);

	count_t     op_joint;
	count_t     wr_joint;
	logic       op_slot;
	logic       wr_slot;
	logic [2:0] op_idx;
	logic [2:0] wr_idx;
	vec3_t      z_op;
	vec3_t      d_op;
	vec3_t      z_wr;

	assign op_joint = count - count_t'(`KIN_SLOT_COL_FIRST);
	assign wr_joint = op_joint - count_t'(1);
	assign op_slot  = en && (op_joint < count_t'(`KIN_JOINTS));
	assign wr_slot  = en && (wr_joint < count_t'(`KIN_JOINTS));
	assign op_idx   = op_joint[2:0];
	assign wr_idx   = wr_joint[2:0];

	assign z_op = pose.z[op_idx];
	assign z_wr = pose.z[wr_idx];

	// lever arm from joint origin to end effector
	always_comb begin
		for (int a = 0; a < 3; a++) begin
			d_op[a] = pose.p_end[a] - pose.p[op_idx][a];
		end
	end

	// z x d as three pairs of products, lanes 0..2 minus lanes 3..5
	always_comb begin
		array_req = '0;
		if (op_slot) begin
			array_req.dataa[0] = z_op[1];
			array_req.dataa[1] = z_op[2];
			array_req.dataa[2] = z_op[0];
			array_req.dataa[3] = z_op[2];
			array_req.dataa[4] = z_op[0];
			array_req.dataa[5] = z_op[1];
			array_req.datab[0] = d_op[2];
			array_req.datab[1] = d_op[0];
			array_req.datab[2] = d_op[1];
			array_req.datab[3] = d_op[1];
			array_req.datab[4] = d_op[2];
			array_req.datab[5] = d_op[0];
		end
	end

	always_ff @(posedge i) begin
		if (rst) begin
			jacobian_matrix <= '0;
		end else if (en && count == count_t'(`KIN_SLOT_CLEAR)) begin
			jacobian_matrix <= '0;
		end else if (wr_slot) begin
			for (int r = 0; r < 3; r++) begin
				if (pose.joint_type[wr_idx]) begin
					// prismatic: pure translation along z
					jacobian_matrix[r][wr_idx]   <= z_wr[r];
					jacobian_matrix[r+3][wr_idx] <= '0;
				end else begin
					jacobian_matrix[r][wr_idx]   <= array_res.result[r] - array_res.result[r+3];
					jacobian_matrix[r+3][wr_idx] <= z_wr[r];
				end
			end
		end
	end

endmodule

//--- full_jacobian/full_jacobian.sv
/*
  J and its transpose sit on the matrix bus during KIN_SLOT_JJT only.
  jjt_bias is loaded at KIN_SLOT_JJT_CAPTURE and kept until the next run.
*/
`timescale 1ns/1ps
`include "kin_cfg.svh"

module full_jacobian
	import fixed_pkg::*;
	import mult_bus_pkg::*;
(
	input  logic       i,
	input  logic       rst,
	input  logic       en,
	input  count_t     count,
	input  pose_t      pose,
	output array_req_t array_req,
	input  array_res_t array_res,
	output mat_req_t   mat_req,
	input  mat_res_t   mat_res,
	output mat6_t      jacobian_matrix,
	output mat6_t      jjt_bias
);

	mat6_t j_t;
	logic  jjt_slot;
	logic  cap_slot;

	jacobian_build u_jacobian_build (
		.i               (i),
		.rst             (rst),
		.en              (en),
		.count           (count),
		.pose            (pose),
		.array_req       (array_req),
		.array_res       (array_res),
		.jacobian_matrix (jacobian_matrix)
	);

	assign jjt_slot = en && (count == count_t'(`KIN_SLOT_JJT));
	assign cap_slot = en && (count == count_t'(`KIN_SLOT_JJT_CAPTURE));

	always_comb begin
		for (int r = 0; r < `KIN_JOINTS; r++) begin
			for (int c = 0; c < `KIN_JOINTS; c++) begin
				j_t[r][c] = jacobian_matrix[c][r];
			end
		end
	end

	// J is complete once the last column lands at the end of the previous slot
	always_comb begin
		mat_req = '0;
		if (jjt_slot) begin
			mat_req.dataa = jacobian_matrix;
			mat_req.datab = j_t;
		end
	end

	// product plus damping on the diagonal
	always_ff @(posedge i) begin
		if (rst) begin
			jjt_bias <= '0;
		end else if (cap_slot) begin
			for (int r = 0; r < `KIN_JOINTS; r++) begin
				for (int c = 0; c < `KIN_JOINTS; c++) begin
					if (r == c) begin
						jjt_bias[r][c] <= mat_res.result[r][c] + fix_t'(`KIN_DAMP_RAW);
					end else begin
						jjt_bias[r][c] <= mat_res.result[r][c];
					end
				end
			end
		end
	end

	// products of J and its transpose come back only in the capture slot
	a_mat_res_slot: assert property (@(posedge i) disable iff (rst)
		!cap_slot |-> (mat_res == '0));

endmodule

//--- logic/ik_jacobian_top.sv
/*
  damped J*J^T slice of the ik engine, frames come in as pose_in.
  start while busy is dropped; results are valid from done until the next run.
*/
`timescale 1ns/1ps

module ik_jacobian_top
	import fixed_pkg::*;
	import mult_bus_pkg::*;
(
	input  logic  i,
	input  logic  rst,
	input  logic  start,
	input  pose_t pose_in,
	output logic  busy,
	output logic  done,
	output mat6_t jacobian_matrix,
	output mat6_t jjt_bias
);

	pose_t      pose;
	count_t     count;
	logic       en;
	array_req_t array_req;
	array_res_t array_res;
	mat_req_t   mat_req;
	mat_res_t   mat_res;

	step_sequencer u_step_sequencer (
		.i       (i),
		.rst     (rst),
		.start   (start),
		.pose_in (pose_in),
		.pose    (pose),
		.count   (count),
		.en      (en),
		.busy    (busy),
		.done    (done)
	);

	full_jacobian u_full_jacobian (
		.i               (i),
		.rst             (rst),
		.en              (en),
		.count           (count),
		.pose            (pose),
		.array_req       (array_req),
		.array_res       (array_res),
		.mat_req         (mat_req),
		.mat_res         (mat_res),
		.jacobian_matrix (jacobian_matrix),
		.jjt_bias        (jjt_bias)
	);

	// one source per bus in this slice
	mult_bank u_mult_bank (
		.i         (i),
		.array_req (array_req),
		.array_res (array_res),
		.mat_req   (mat_req),
		.mat_res   (mat_res)
	);

endmodule

//--- verif/tb_ik_jacobian.sv
/*
  table-driven testbench for ik_jacobian_top, inputs change on the falling edge.
  expected J and damped J*J^T come from a model of the column and truncation rules.
*/
`timescale 1ns/1ps
`include "kin_cfg.svh"

module tb_ik_jacobian
	import fixed_pkg::*;
;

	localparam int N_ROWS = 9;
	localparam int TIMEOUT_CYCLES = 50;
	// accepting edge plus ten schedule steps
	localparam int DONE_EDGES = 11;
	localparam int ONE = 65536;

	logic  i;
	logic  rst;
	logic  start;
	pose_t pose_in;
	logic  busy;
	logic  done;
	mat6_t jacobian_matrix;
	mat6_t jjt_bias;

	pose_t       poses [N_ROWS];
	mat6_t       exp_j [N_ROWS];
	mat6_t       exp_jjt [N_ROWS];
	string       names [N_ROWS];
	logic        intrude [N_ROWS];
	logic        gap [N_ROWS];
	int          errors;
	int          tests_passed;
	int          tests_failed;
	logic        timed_out;

	ik_jacobian_top i_dut (
		.i               (i),
		.rst             (rst),
		.start           (start),
		.pose_in         (pose_in),
		.busy            (busy),
		.done            (done),
		.jacobian_matrix (jacobian_matrix),
		.jjt_bias        (jjt_bias)
	);

	initial begin
		i = 1'b0;
		forever #4 i = ~i;
	end

	// product shifted right arithmetically, then cut to scalar width
	function automatic fix_t fx_mul(input fix_t a, input fix_t b);
		longint prod;
		prod = longint'(a) * longint'(b);
		prod = prod >>> `KIN_FRAC;
		return fix_t'(prod);
	endfunction

	// signed value in about +-8.0
	function automatic fix_t rnd_fix();
		logic [31:0]        v;
		logic signed [19:0] s;
		v = $urandom;
		s = v[19:0];
		return fix_t'(s);
	endfunction

	// kinds 0 revolute, 1 prismatic, 2 alternating, 3 zero, 4 negative
	function automatic pose_t fixed_pose(input int kind);
		pose_t ps;
		ps = '0;
		if (kind != 3) begin
			for (int k = 0; k < `KIN_JOINTS; k++) begin
				ps.z[k][k % 3]   = fix_t'(ONE);
				ps.p[k][0]       = fix_t'(k * 32768);
				ps.p[k][1]       = fix_t'(k * 16384 - 40000);
				ps.p[k][2]       = fix_t'(ONE + k * 8192);
				if (kind == 4) begin
					ps.z[k][k % 3]       = fix_t'(-ONE);
					ps.z[k][(k + 1) % 3] = fix_t'(-ONE / 2);
					for (int a = 0; a < 3; a++) begin
						ps.p[k][a] = -ps.p[k][a] - fix_t'(ONE / 4);
					end
				end
			end
			ps.p_end[0] = fix_t'(3 * ONE);
			ps.p_end[1] = fix_t'(ONE + ONE / 2);
			ps.p_end[2] = fix_t'(2 * ONE);
			if (kind == 4) begin
				ps.p_end[0] = fix_t'(-3 * ONE);
				ps.p_end[1] = fix_t'(-ONE / 8);
			end
		end
		case (kind)
			1:       ps.joint_type = 6'b111111;
			2:       ps.joint_type = 6'b101010;
			4:       ps.joint_type = 6'b010011;
			default: ps.joint_type = 6'b000000;
		endcase
		return ps;
	endfunction

	function automatic pose_t random_pose();
		pose_t       ps;
		logic [31:0] v;
		for (int k = 0; k < `KIN_JOINTS; k++) begin
			for (int a = 0; a < 3; a++) begin
				ps.z[k][a] = rnd_fix();
				ps.p[k][a] = rnd_fix();
			end
		end
		for (int a = 0; a < 3; a++) begin
			ps.p_end[a] = rnd_fix();
		end
		v = $urandom;
		ps.joint_type = v[5:0];
		return ps;
	endfunction

	// revolute column is (z x d, z), prismatic column is (z, 0)
	task automatic model_pose(input pose_t ps, output mat6_t jm, output mat6_t jj);
		vec3_t z;
		vec3_t d;
		fix_t  acc;
		for (int k = 0; k < `KIN_JOINTS; k++) begin
			z = ps.z[k];
			for (int a = 0; a < 3; a++) begin
				d[a] = ps.p_end[a] - ps.p[k][a];
			end
			if (ps.joint_type[k]) begin
				for (int a = 0; a < 3; a++) begin
					jm[a][k]     = z[a];
					jm[a + 3][k] = '0;
				end
			end else begin
				jm[0][k] = fx_mul(z[1], d[2]) - fx_mul(z[2], d[1]);
				jm[1][k] = fx_mul(z[2], d[0]) - fx_mul(z[0], d[2]);
				jm[2][k] = fx_mul(z[0], d[1]) - fx_mul(z[1], d[0]);
				for (int a = 0; a < 3; a++) begin
					jm[a + 3][k] = z[a];
				end
			end
		end
		for (int r = 0; r < `KIN_JOINTS; r++) begin
			for (int c = 0; c < `KIN_JOINTS; c++) begin
				acc = (r == c) ? fix_t'(`KIN_DAMP_RAW) : fix_t'(0);
				for (int k = 0; k < `KIN_JOINTS; k++) begin
					acc = acc + fx_mul(jm[r][k], jm[c][k]);
				end
				jj[r][c] = acc;
			end
		end
	endtask

	task automatic compare_bit(input string name, input logic got, input logic exp);
		if (got !== exp) begin
			$display("mismatch at %0t: %s got %b expected %b", $time, name, got, exp);
			errors++;
		end
	endtask

	task automatic compare_matrix(input string name, input mat6_t got, input mat6_t exp);
		for (int r = 0; r < `KIN_JOINTS; r++) begin
			for (int c = 0; c < `KIN_JOINTS; c++) begin
				if (got[r][c] !== exp[r][c]) begin
					$display("mismatch at %0t: %s[%0d][%0d] got %0d expected %0d",
						$time, name, r, c, got[r][c], exp[r][c]);
					errors++;
				end
			end
		end
	endtask

	// entered on a falling edge, leaves on a falling edge with the DUT idle
	task automatic apply_row(input int t);
		int   cycles;
		int   errors_before;
		logic seen;
		errors_before = errors;
		pose_in = poses[t];
		start = 1'b1;
		cycles = 0;
		seen = 1'b0;
		while (!seen && cycles < TIMEOUT_CYCLES) begin
			@(negedge i);
			cycles++;
			if (done === 1'b1) begin
				seen = 1'b1;
			end else begin
				compare_bit("busy", busy, 1'b1);
			end
			if (cycles == 1) begin
				start = 1'b0;
			end
			// second start with another pose while the run is going
			if (intrude[t] && cycles == 3) begin
				start = 1'b1;
				pose_in = ~poses[t];
			end
			if (intrude[t] && cycles == 4) begin
				start = 1'b0;
			end
		end
		if (!seen) begin
			$display("timeout: done did not rise within %0d cycles in test %0d",
				TIMEOUT_CYCLES, t);
			errors++;
			timed_out = 1'b1;
		end else begin
			if (cycles != DONE_EDGES) begin
				$display("mismatch at %0t: done_edges got %0d expected %0d",
					$time, cycles, DONE_EDGES);
				errors++;
			end
			compare_bit("busy", busy, 1'b1);
			compare_matrix("jacobian_matrix", jacobian_matrix, exp_j[t]);
			compare_matrix("jjt_bias", jjt_bias, exp_jjt[t]);
			@(negedge i);
			compare_bit("done", done, 1'b0);
			compare_bit("busy", busy, 1'b0);
			if (gap[t]) begin
				repeat (3) @(negedge i);
				compare_matrix("jacobian_matrix", jacobian_matrix, exp_j[t]);
				compare_matrix("jjt_bias", jjt_bias, exp_jjt[t]);
			end
		end
		if (errors == errors_before) begin
			tests_passed++;
			$display("test %0d (%s): ok", t, names[t]);
		end else begin
			tests_failed++;
			$display("test %0d (%s): %0d checks failed", t, names[t], errors - errors_before);
		end
	endtask

	initial begin
		void'($urandom(32'h3f84));
		rst = 1'b1;
		start = 1'b0;
		pose_in = '0;
		errors = 0;
		tests_passed = 0;
		tests_failed = 0;
		timed_out = 1'b0;

		names[0] = "all revolute";
		names[1] = "all prismatic";
		names[2] = "alternating";
		names[3] = "all zero";
		names[4] = "negative coordinates";
		for (int t = 0; t < N_ROWS; t++) begin
			if (t < 5) begin
				poses[t] = fixed_pose(t);
			end else begin
				poses[t] = random_pose();
				names[t] = $sformatf("random %0d", t - 5);
			end
			model_pose(poses[t], exp_j[t], exp_jjt[t]);
			intrude[t] = (t % 3 == 0);
			gap[t] = (t % 3 == 1);
		end

		repeat (8) @(posedge i);
		@(negedge i);
		rst = 1'b0;

		// idle state straight after reset
		compare_bit("busy", busy, 1'b0);
		compare_bit("done", done, 1'b0);
		compare_matrix("jacobian_matrix", jacobian_matrix, '0);
		compare_matrix("jjt_bias", jjt_bias, '0);

		for (int t = 0; t < N_ROWS; t++) begin
			if (!timed_out) begin
				apply_row(t);
			end
		end

		$display("tests passed %0d, tests failed %0d, checks failed %0d",
			tests_passed, tests_failed, errors);
		if (errors == 0 && !timed_out) begin
			$display("Simulation passed");
		end else begin
			$display("Simulation failed");
		end
		$finish;
	end

endmodule

//--- files.f
+incdir+common
common/fixed_pkg.sv
common/mult_bus_pkg.sv
logic/step_sequencer.sv
logic/mult_bank.sv
full_jacobian/jacobian_build.sv
full_jacobian/full_jacobian.sv
logic/ik_jacobian_top.sv
verif/tb_ik_jacobian.sv
